// File: source/systolic_mm_settings.svh
// size and width macros for the systolic matrix multiplier; include wherever a width is needed
`ifndef SYSTOLIC_MM_SETTINGS_SVH
`define SYSTOLIC_MM_SETTINGS_SVH

// operand element width, unsigned
`define SMM_DATA_WIDTH 4
// result element and partial sum width
`define SMM_ACCUM_WIDTH 16

// pe array edge
`define SMM_TILE 4
// operand matrix edge
`define SMM_DIM 8

// derived counts
`define SMM_TILES (`SMM_DIM / `SMM_TILE)
// skewed stream length, also used for the flush
`define SMM_STEPS (2 * `SMM_TILE - 1)
`define SMM_ELEMS (`SMM_DIM * `SMM_DIM)

`endif

// File: source/systolic_mm_pkg.sv
// shared types of the systolic matrix multiplier, referenced by scoped name from every block
`include "systolic_mm_settings.svh"

package systolic_mm_pkg;

    // scalar widths with a meaning
    typedef logic [`SMM_DATA_WIDTH-1:0] data_t;
    typedef logic [`SMM_ACCUM_WIDTH-1:0] accum_t;
    typedef logic [$clog2(`SMM_TILES)-1:0] tile_idx_t;
    typedef logic [$clog2(`SMM_ELEMS)-1:0] elem_idx_t;
    typedef logic [$clog2(`SMM_STEPS+1)-1:0] step_t;

    // element e sits at bits [e*width +: width], row-major
    typedef logic [`SMM_ELEMS*`SMM_DATA_WIDTH-1:0] matrix_t;
    typedef logic [`SMM_TILE*`SMM_DATA_WIDTH-1:0] edge_t;
    // cell (r, c) at slot r*TILE + c
    typedef logic [`SMM_TILE*`SMM_TILE*`SMM_ACCUM_WIDTH-1:0] tile_sums_t;

    typedef struct packed {
        edge_t left;
        edge_t top;
    } feed_t;

    typedef struct packed {
        tile_idx_t ib;
        tile_idx_t jb;
        tile_idx_t kb;
    } tile_pos_t;

    typedef struct packed {
        elem_idx_t index;
        accum_t value;
    } result_word_t;

    typedef enum logic [2:0] {IDLE, CLEAR, STREAM, FLUSH, COLLECT, NEXT, DRAIN} seq_state_t;

endpackage

// File: source/pe_cell.sv
// one systolic multiply-accumulate cell; operands pass on to the right and bottom neighbours
`timescale 1ns/10ps

module pe_cell #(
    parameter int data_width = 4,
    parameter int accum_width = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic [data_width-1:0]  left_in,
    input  logic [data_width-1:0]  top_in,
    output logic [data_width-1:0]  right_out,
    output logic [data_width-1:0]  bottom_out,
    output logic [accum_width-1:0] sum
);

    logic [accum_width-1:0] prod;

    // unsigned product at full accumulator width
    assign prod = accum_width'(left_in) * accum_width'(top_in);

    always_ff @(posedge clk) begin
        if (rst) begin
            right_out <= '0;
            bottom_out <= '0;
            sum <= '0;
        end else begin
            // one cycle hop to the neighbours
            right_out <= left_in;
            bottom_out <= top_in;
            sum <= clear ? '0 : sum + prod;
        end
    end

endmodule

// File: source/pe_array.sv
// square grid of MAC cells; A flows right along rows, B flows down columns
`timescale 1ns/10ps
`include "systolic_mm_settings.svh"

module pe_array (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  systolic_mm_pkg::feed_t      feed,
    output systolic_mm_pkg::tile_sums_t sums
);

    // column 0 of h_link and row 0 of v_link are the edge inputs
    systolic_mm_pkg::data_t h_link [`SMM_TILE][`SMM_TILE+1];
    systolic_mm_pkg::data_t v_link [`SMM_TILE+1][`SMM_TILE];

    for (genvar n = 0; n < `SMM_TILE; n++) begin : g_edge
        assign h_link[n][0] = feed.left[n*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH];
        assign v_link[0][n] = feed.top[n*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH];
    end

    for (genvar r = 0; r < `SMM_TILE; r++) begin : g_row
        for (genvar c = 0; c < `SMM_TILE; c++) begin : g_col
            pe_cell #(
                .data_width  (`SMM_DATA_WIDTH),
                .accum_width (`SMM_ACCUM_WIDTH)
            ) u_cell (
                .clk        (clk),
                .rst        (rst),
                .clear      (clear),
                .left_in    (h_link[r][c]),
                .top_in     (v_link[r][c]),
                .right_out  (h_link[r][c+1]),
                .bottom_out (v_link[r+1][c]),
                // sum of cell (r, c) into slot r*T+c
                .sum        (sums[(r*`SMM_TILE+c)*`SMM_ACCUM_WIDTH +: `SMM_ACCUM_WIDTH])
            );
        end
    end

endmodule

// File: source/operand_loader.sv
// four-phase receiver that fills the A then B operand stores, one element per transfer
`timescale 1ns/10ps
`include "systolic_mm_settings.svh"

module operand_loader (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_req,
    input  systolic_mm_pkg::data_t   in_data,
    output logic                     in_ack,
    output systolic_mm_pkg::matrix_t a_mat,
    output systolic_mm_pkg::matrix_t b_mat,
    output logic                     operands_ready
);

    // counts A words then B words, msb picks the store
    localparam int cnt_width = $clog2(2 * `SMM_ELEMS);

    logic [cnt_width-1:0] word_cnt;
    systolic_mm_pkg::elem_idx_t wr_idx;
    logic new_word;

    // row-major position inside the selected matrix
    assign wr_idx = systolic_mm_pkg::elem_idx_t'(word_cnt);
    // req seen high while ack still low starts a transfer
    assign new_word = in_req && !in_ack;

    // handshake and word counter
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack <= 1'b0;
            word_cnt <= '0;
            operands_ready <= 1'b0;
        end else begin
            operands_ready <= 1'b0;
            if (new_word) begin
                in_ack <= 1'b1;
                // wraps to zero, ready for the next job
                word_cnt <= word_cnt + 1'b1;
                // last B word
                operands_ready <= &word_cnt;
            end else if (!in_req && in_ack) begin
                in_ack <= 1'b0;
            end
        end
    end

    // operand stores
    always_ff @(posedge clk) begin
        if (new_word) begin
            if (word_cnt[cnt_width-1]) begin
                b_mat[wr_idx*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH] <= in_data;
            end else begin
                a_mat[wr_idx*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH] <= in_data;
            end
        end
    end

endmodule

// File: source/tile_sequencer.sv
// tile sequencer FSM; walks every (ib, jb, kb) triple and orders clear, stream, flush, collect
`timescale 1ns/10ps
`include "systolic_mm_settings.svh"

module tile_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       operands_ready,
    input  logic                       drain_done,
    output systolic_mm_pkg::tile_pos_t pos,
    output systolic_mm_pkg::step_t     step,
    output logic                       streaming,
    output logic                       clear,
    output logic                       collect,
    output logic                       start_job,
    output logic                       drain
);

    localparam systolic_mm_pkg::tile_idx_t last_blk = systolic_mm_pkg::tile_idx_t'(`SMM_TILES - 1);
    localparam systolic_mm_pkg::step_t last_step = systolic_mm_pkg::step_t'(`SMM_STEPS - 1);

    systolic_mm_pkg::seq_state_t state;
    logic last_tile;

    assign last_tile = (pos.ib == last_blk) && (pos.jb == last_blk) && (pos.kb == last_blk);

    // controls decoded from state
    assign clear = (state == systolic_mm_pkg::CLEAR);
    assign streaming = (state == systolic_mm_pkg::STREAM);
    assign collect = (state == systolic_mm_pkg::COLLECT);
    assign start_job = (state == systolic_mm_pkg::IDLE) && operands_ready;
    assign drain = (state == systolic_mm_pkg::NEXT) && last_tile;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= systolic_mm_pkg::IDLE;
            pos <= '0;
            step <= '0;
        end else begin
            case (state)
                systolic_mm_pkg::IDLE: begin
                    pos <= '0;
                    if (operands_ready) begin
                        state <= systolic_mm_pkg::CLEAR;
                    end
                end
                systolic_mm_pkg::CLEAR: begin
                    step <= '0;
                    state <= systolic_mm_pkg::STREAM;
                end
                // skewed edges go in
                systolic_mm_pkg::STREAM: begin
                    if (step == last_step) begin
                        step <= '0;
                        state <= systolic_mm_pkg::FLUSH;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                // zeros push the last products through
                systolic_mm_pkg::FLUSH: begin
                    if (step == last_step) begin
                        step <= '0;
                        state <= systolic_mm_pkg::COLLECT;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                systolic_mm_pkg::COLLECT: begin
                    state <= systolic_mm_pkg::NEXT;
                end
                // kb innermost, then jb, then ib; all wrap to zero after the last tile
                systolic_mm_pkg::NEXT: begin
                    if (pos.kb == last_blk) begin
                        pos.kb <= '0;
                        if (pos.jb == last_blk) begin
                            pos.jb <= '0;
                            pos.ib <= pos.ib + 1'b1;
                        end else begin
                            pos.jb <= pos.jb + 1'b1;
                        end
                    end else begin
                        pos.kb <= pos.kb + 1'b1;
                    end
                    state <= last_tile ? systolic_mm_pkg::DRAIN : systolic_mm_pkg::CLEAR;
                end
                // read-out runs in the result store
                systolic_mm_pkg::DRAIN: begin
                    if (drain_done) begin
                        state <= systolic_mm_pkg::IDLE;
                    end
                end
                default: begin
                    state <= systolic_mm_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/skew_feeder.sv
// registered edge feeder; slices the current tile out of A and B and skews it by lane
`timescale 1ns/10ps
`include "systolic_mm_settings.svh"

module skew_feeder (
    input  logic                       clk,
    input  logic                       rst,
    input  systolic_mm_pkg::matrix_t   a_mat,
    input  systolic_mm_pkg::matrix_t   b_mat,
    input  systolic_mm_pkg::tile_pos_t pos,
    input  systolic_mm_pkg::step_t     step,
    input  logic                       streaming,
    output systolic_mm_pkg::feed_t     feed
);

    always_ff @(posedge clk) begin : feed_reg
        int lag;
        int a_idx;
        int b_idx;
        if (rst) begin
            feed <= '0;
        end else begin
            for (int lane = 0; lane < `SMM_TILE; lane++) begin
                // lane n starts n steps late
                lag = int'(step) - lane;
                if (streaming && lag >= 0 && lag < `SMM_TILE) begin
                    // A row ib*T+lane, column kb*T+lag
                    a_idx = (int'(pos.ib) * `SMM_TILE + lane) * `SMM_DIM
                            + int'(pos.kb) * `SMM_TILE + lag;
                    // B row kb*T+lag, column jb*T+lane
                    b_idx = (int'(pos.kb) * `SMM_TILE + lag) * `SMM_DIM
                            + int'(pos.jb) * `SMM_TILE + lane;
                    feed.left[lane*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH] <=
                        a_mat[a_idx*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH];
                    feed.top[lane*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH] <=
                        b_mat[b_idx*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH];
                end else begin
                    // outside the diagonal band, and whole flush
                    feed.left[lane*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH] <= '0;
                    feed.top[lane*`SMM_DATA_WIDTH +: `SMM_DATA_WIDTH] <= '0;
                end
            end
        end
    end

endmodule

// File: source/result_store.sv
// result matrix store; adds tile sums per block and serves all entries over four-phase req/ack
`timescale 1ns/10ps
`include "systolic_mm_settings.svh"

module result_store (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_job,
    input  logic                          collect,
    input  systolic_mm_pkg::tile_pos_t    pos,
    input  systolic_mm_pkg::tile_sums_t   sums,
    input  logic                          drain,
    output logic                          drain_done,
    output logic                          out_req,
    output systolic_mm_pkg::result_word_t out_word,
    input  logic                          out_ack,
    output logic                          done
);

    systolic_mm_pkg::accum_t acc_mem [`SMM_ELEMS];
    systolic_mm_pkg::elem_idx_t rd_idx;
    logic serving;

    // word on offer follows the read index
    assign out_word = '{index: rd_idx, value: acc_mem[rd_idx]};

    // zero on a new job, block-wise accumulate on collect
    always_ff @(posedge clk) begin : accumulate
        int idx;
        if (start_job) begin
            for (int e = 0; e < `SMM_ELEMS; e++) begin
                acc_mem[e] <= '0;
            end
        end else if (collect) begin
            for (int r = 0; r < `SMM_TILE; r++) begin
                for (int c = 0; c < `SMM_TILE; c++) begin
                    idx = (int'(pos.ib) * `SMM_TILE + r) * `SMM_DIM
                          + int'(pos.jb) * `SMM_TILE + c;
                    acc_mem[idx] <= acc_mem[idx]
                        + sums[(r*`SMM_TILE+c)*`SMM_ACCUM_WIDTH +: `SMM_ACCUM_WIDTH];
                end
            end
        end
    end

    // output handshake and read-out progress
    always_ff @(posedge clk) begin
        if (rst) begin
            out_req <= 1'b0;
            rd_idx <= '0;
            serving <= 1'b0;
            drain_done <= 1'b0;
            done <= 1'b0;
        end else begin
            drain_done <= 1'b0;
            if (start_job) begin
                done <= 1'b0;
            end
            if (drain) begin
                serving <= 1'b1;
                rd_idx <= '0;
                out_req <= 1'b1;
            end else if (serving) begin
                if (out_req && out_ack) begin
                    out_req <= 1'b0;
                end else if (!out_req && !out_ack) begin
                    // ack seen low, finish or offer the next word
                    if (rd_idx == systolic_mm_pkg::elem_idx_t'(`SMM_ELEMS - 1)) begin
                        serving <= 1'b0;
                        drain_done <= 1'b1;
                        done <= 1'b1;
                    end else begin
                        rd_idx <= rd_idx + 1'b1;
                        out_req <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: source/systolic_mm_top.sv
// top level of the systolic matrix multiplier; connects loader, sequencer, feeder, array, store
`timescale 1ns/10ps
`include "systolic_mm_settings.svh"

module systolic_mm_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_req,
    input  systolic_mm_pkg::data_t        in_data,
    output logic                          in_ack,
    output logic                          out_req,
    output systolic_mm_pkg::result_word_t out_word,
    input  logic                          out_ack,
    output logic                          done
);

    // operand stores
    systolic_mm_pkg::matrix_t a_mat;
    systolic_mm_pkg::matrix_t b_mat;
    logic operands_ready;

    // sequencer controls
    systolic_mm_pkg::tile_pos_t pos;
    systolic_mm_pkg::step_t step;
    logic streaming;
    logic clear;
    logic collect;
    logic start_job;
    logic drain;
    logic drain_done;

    // datapath
    systolic_mm_pkg::feed_t feed;
    systolic_mm_pkg::tile_sums_t sums;

    operand_loader u_loader (
        .clk            (clk),
        .rst            (rst),
        .in_req         (in_req),
        .in_data        (in_data),
        .in_ack         (in_ack),
        .a_mat          (a_mat),
        .b_mat          (b_mat),
        .operands_ready (operands_ready)
    );

    tile_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .operands_ready (operands_ready),
        .drain_done     (drain_done),
        .pos            (pos),
        .step           (step),
        .streaming      (streaming),
        .clear          (clear),
        .collect        (collect),
        .start_job      (start_job),
        .drain          (drain)
    );

    skew_feeder u_feeder (
        .clk       (clk),
        .rst       (rst),
        .a_mat     (a_mat),
        .b_mat     (b_mat),
        .pos       (pos),
        .step      (step),
        .streaming (streaming),
        .feed      (feed)
    );

    pe_array u_array (
        .clk   (clk),
        .rst   (rst),
        .clear (clear),
        .feed  (feed),
        .sums  (sums)
    );

    result_store u_store (
        .clk        (clk),
        .rst        (rst),
        .start_job  (start_job),
        .collect    (collect),
        .pos        (pos),
        .sums       (sums),
        .drain      (drain),
        .drain_done (drain_done),
        .out_req    (out_req),
        .out_word   (out_word),
        .out_ack    (out_ack),
        .done       (done)
    );

endmodule

// File: tests/tb_clock.sv
// testbench clock and reset source; 10 ns clock, reset held high for the first 8 rising edges
`timescale 1ns/10ps

module tb_clock #(
    parameter int half_period = 5,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // synchronous reset, released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tests/systolic_mm_tb.sv
// testbench for the systolic matrix multiplier; runs a table of jobs back to back and checks C
`timescale 1ns/10ps
`include "systolic_mm_settings.svh"

module systolic_mm_tb;

    // fill codes for an operand matrix
    localparam logic [1:0] fill_zero = 2'd0;
    localparam logic [1:0] fill_ident = 2'd1;
    localparam logic [1:0] fill_max = 2'd2;
    localparam logic [1:0] fill_rand = 2'd3;

    typedef struct packed {
        logic [1:0] a_fill;
        logic [1:0] b_fill;
        logic [3:0] max_delay;
    } case_t;

    localparam int num_cases = 6;
    localparam int elem_max = (1 << `SMM_DATA_WIDTH) - 1;

    // one job per row, applied without reset in between
    localparam case_t case_tab [num_cases] = '{
        '{fill_zero, fill_rand, 4'd0},
        '{fill_ident, fill_rand, 4'd0},
        '{fill_max, fill_max, 4'd0},
        '{fill_rand, fill_rand, 4'd3},
        '{fill_rand, fill_ident, 4'd5},
        '{fill_rand, fill_rand, 4'd7}
    };

    logic clk;
    logic rst;
    logic in_req;
    systolic_mm_pkg::data_t in_data;
    logic in_ack;
    logic out_req;
    systolic_mm_pkg::result_word_t out_word;
    logic out_ack;
    logic done;

    int a_val [`SMM_ELEMS];
    int b_val [`SMM_ELEMS];
    int exp_val [`SMM_ELEMS];
    int cycle_count = 0;
    int cycle_limit = 0;

    // handshake monitor state
    logic prev_req = 1'b0;
    logic prev_ack = 1'b0;
    systolic_mm_pkg::result_word_t prev_word = '0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    systolic_mm_top DUT (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_word (out_word),
        .out_ack  (out_ack),
        .done     (done)
    );

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, expected));
        end
    endtask

    // element of an operand matrix for a fill code
    function automatic int fill_value(logic [1:0] fill, int row, int col);
        case (fill)
            fill_zero: return 0;
            fill_ident: return (row == col) ? 1 : 0;
            fill_max: return elem_max;
            default: return int'($urandom % (elem_max + 1));
        endcase
    endfunction

    function automatic int random_delay(int max_delay);
        return (max_delay == 0) ? 0 : int'($urandom % (max_delay + 1));
    endfunction

    // load, compute and read-out cycles per row, plus reset, doubled
    function automatic int run_budget();
        int total;
        total = 8;
        for (int n = 0; n < num_cases; n++) begin
            total += 4 * 2 * `SMM_ELEMS;
            total += 17 * `SMM_TILES * `SMM_TILES * `SMM_TILES;
            total += `SMM_ELEMS * (4 + 2 * int'(case_tab[n].max_delay));
        end
        return 2 * total;
    endfunction

    task automatic fill_operands(case_t tc);
        for (int i = 0; i < `SMM_DIM; i++) begin
            for (int j = 0; j < `SMM_DIM; j++) begin
                a_val[i*`SMM_DIM+j] = fill_value(tc.a_fill, i, j);
                b_val[i*`SMM_DIM+j] = fill_value(tc.b_fill, i, j);
            end
        end
    endtask

    // C = A x B, with the trivial cases taken straight from the operands
    task automatic build_expected(case_t tc);
        int sum;
        int e;
        for (int i = 0; i < `SMM_DIM; i++) begin
            for (int j = 0; j < `SMM_DIM; j++) begin
                e = i * `SMM_DIM + j;
                sum = 0;
                for (int k = 0; k < `SMM_DIM; k++) begin
                    sum += a_val[i*`SMM_DIM+k] * b_val[k*`SMM_DIM+j];
                end
                if (tc.a_fill == fill_zero || tc.b_fill == fill_zero) begin
                    exp_val[e] = 0;
                end else if (tc.a_fill == fill_ident) begin
                    exp_val[e] = b_val[e];
                end else if (tc.b_fill == fill_ident) begin
                    exp_val[e] = a_val[e];
                end else if (tc.a_fill == fill_max && tc.b_fill == fill_max) begin
                    // 8 * 15 * 15 = 1800
                    exp_val[e] = `SMM_DIM * elem_max * elem_max;
                end else begin
                    exp_val[e] = sum;
                end
            end
        end
    endtask

    task automatic wait_in_ack(logic level);
        @(negedge clk);
        while (in_ack !== level) @(negedge clk);
    endtask

    // one four-phase transfer to the loader
    task automatic send_word(int value);
        @(posedge clk);
        in_req <= 1'b1;
        in_data <= systolic_mm_pkg::data_t'(value);
        wait_in_ack(1'b1);
        @(posedge clk);
        in_req <= 1'b0;
        wait_in_ack(1'b0);
    endtask

    // A row-major, then B row-major
    task automatic load_operands();
        for (int e = 0; e < `SMM_ELEMS; e++) begin
            send_word(a_val[e]);
        end
        for (int e = 0; e < `SMM_ELEMS; e++) begin
            send_word(b_val[e]);
        end
    endtask

    // accept all 64 words with random ack delays
    task automatic read_results(int max_delay);
        systolic_mm_pkg::result_word_t word;
        for (int e = 0; e < `SMM_ELEMS; e++) begin
            @(negedge clk);
            while (!out_req) @(negedge clk);
            word = out_word;
            check_value("out_word.index", 32'(word.index), e);
            check_value("out_word.value", 32'(word.value), exp_val[e]);
            // done stays low until the 64th word has gone
            check_value("done", 32'(done), 0);
            repeat (random_delay(max_delay)) @(posedge clk);
            @(posedge clk);
            out_ack <= 1'b1;
            @(negedge clk);
            while (out_req) @(negedge clk);
            repeat (random_delay(max_delay)) @(posedge clk);
            @(posedge clk);
            out_ack <= 1'b0;
        end
    endtask

    // out_req only falls after ack, word holds while offered
    always @(negedge clk) begin
        if (rst) begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
        end else begin
            if (prev_req && !out_req) begin
                check_value("out_ack at out_req fall", 32'(prev_ack), 1);
            end
            if (prev_req && out_req) begin
                check_value("out_word while offered", 32'(out_word), 32'(prev_word));
            end
            prev_req = out_req;
            prev_ack = out_ack;
            prev_word = out_word;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            fail_run("timeout: the run did not finish within its cycle budget");
        end
    end

    initial begin : run
        case_t tc;
        in_req = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        void'($urandom(32'h3635));
        cycle_limit = run_budget();
        @(negedge clk);
        while (rst) @(negedge clk);
        // idle outputs after reset
        check_value("in_ack", 32'(in_ack), 0);
        check_value("out_req", 32'(out_req), 0);
        check_value("done", 32'(done), 0);
        for (int n = 0; n < num_cases; n++) begin
            tc = case_tab[n];
            fill_operands(tc);
            build_expected(tc);
            load_operands();
            read_results(int'(tc.max_delay));
            // last ack drop is seen on the next edge, done follows it
            @(negedge clk);
            check_value("done", 32'(done), 0);
            @(negedge clk);
            check_value("done", 32'(done), 1);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: systolic_mm.f
+incdir+source
source/systolic_mm_pkg.sv
source/pe_cell.sv
source/pe_array.sv
source/operand_loader.sv
source/tile_sequencer.sv
source/skew_feeder.sv
source/result_store.sv
source/systolic_mm_top.sv
tests/tb_clock.sv
tests/systolic_mm_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal --timescale 1ns/10ps
TOP       = systolic_mm_tb
FILELIST  = systolic_mm.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
